/* verilog/lsu_pkg.sv */
package lsu_pkg;

	// word width for data and byte addresses
	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	// access sizes in bytes, wide enough to add to a beat offset
	localparam logic [3:0] SIZE_BYTE = 4'd1;
	localparam logic [3:0] SIZE_HALF = 4'd2;
	localparam logic [3:0] SIZE_WORD = 4'd4;

	typedef enum logic [2:0] {
		OP_LB,
		OP_LBU,
		OP_LH,
		OP_LHU,
		OP_LW,
		OP_SB,
		OP_SH,
		OP_SW
	} mem_op_e;

	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	function automatic logic [3:0] op_size(mem_op_e op);
		case (op)
			OP_LB, OP_LBU, OP_SB: return SIZE_BYTE;
			OP_LH, OP_LHU, OP_SH: return SIZE_HALF;
			default: return SIZE_WORD;
		endcase
	endfunction

	function automatic logic op_is_store(mem_op_e op);
		return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
	endfunction

endpackage

/* verilog/mem_bus_pkg.sv */
package mem_bus_pkg;

	// one beat on the data bus
	localparam int BEAT_W = 64;
	localparam int STRB_W = 8;
	localparam int OFFSET_W = 3;
	localparam int BEAT_BYTES = 8;

	// write channel, suffix gives the beat
	typedef enum logic [2:0] {
		WR_IDLE0,
		WR_ADDR0,
		WR_DATA0,
		WR_RESP0,
		WR_IDLE1,
		WR_ADDR1,
		WR_DATA1,
		WR_RESP1
	} wr_state_e;

	// read channel, suffix gives the beat
	typedef enum logic [2:0] {
		RD_IDLE0,
		RD_ADDR0,
		RD_DATA0,
		RD_IDLE1,
		RD_ADDR1,
		RD_DATA1
	} rd_state_e;

endpackage

/* verilog/lsu_issue.sv */
`timescale 1ns/1ps

module lsu_issue (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               req_valid,
	input  lsu_pkg::mem_op_e                   req_op,
	input  logic [lsu_pkg::XLEN-1:0]           req_addr,
	input  logic [lsu_pkg::XLEN-1:0]           req_wdata,
	input  lsu_pkg::reg_addr_t                 req_rd,
	input  logic                               wr_done,
	input  logic                               rd_done,
	output logic                               req_ready,
	output lsu_pkg::mem_op_e                   op,
	output logic [mem_bus_pkg::OFFSET_W-1:0]   offset,
	output logic [lsu_pkg::XLEN-1:0]           store_data,
	output logic [lsu_pkg::XLEN-1:0]           beat_addr,
	output logic                               two_beats,
	output logic                               wr_start,
	output logic                               rd_start,
	output logic                               mem_done,
	output logic                               rf_wen,
	output lsu_pkg::reg_addr_t                 rf_waddr
);
	import lsu_pkg::*;
	import mem_bus_pkg::*;

	logic            busy;
	logic            accept;
	logic [XLEN-1:0] addr_q;
	logic [3:0]      access_end;

	assign req_ready = !busy;
	assign accept = req_valid && req_ready;

	// busy from accept until the done cycle, starts go out one cycle later
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			wr_start <= 1'b0;
			rd_start <= 1'b0;
		end else begin
			if (accept)
				busy <= 1'b1;
			else if (mem_done)
				busy <= 1'b0;
			wr_start <= accept && op_is_store(req_op);
			rd_start <= accept && !op_is_store(req_op);
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op <= req_op;
			addr_q <= req_addr;
			store_data <= req_wdata;
			rf_waddr <= req_rd;
		end
	end

	// beat planning
	assign offset = addr_q[OFFSET_W-1:0];
	assign beat_addr = {addr_q[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};
	assign access_end = {1'b0, offset} + op_size(op);
	assign two_beats = access_end > BEAT_BYTES;

	assign mem_done = wr_done || rd_done;
	assign rf_wen = rd_done;

	assert property (@(posedge clock) disable iff (reset) !(wr_start && rd_start));
	// a channel only finishes while a request is held
	assert property (@(posedge clock) disable iff (reset) mem_done |-> busy);

endmodule

/* verilog/store_align.sv */
`timescale 1ns/1ps

module store_align (
	input  lsu_pkg::mem_op_e                   op,
	input  logic [mem_bus_pkg::OFFSET_W-1:0]   offset,
	input  logic [lsu_pkg::XLEN-1:0]           store_data,
	output logic [mem_bus_pkg::BEAT_W-1:0]     beat0_wdata,
	output logic [mem_bus_pkg::BEAT_W-1:0]     beat1_wdata,
	output logic [mem_bus_pkg::STRB_W-1:0]     beat0_strb,
	output logic [mem_bus_pkg::STRB_W-1:0]     beat1_strb
);
	import lsu_pkg::*;
	import mem_bus_pkg::*;

	logic [2*BEAT_W-1:0] data_image;
	logic [2*STRB_W-1:0] strb_image;
	logic [STRB_W-1:0]   size_mask;

	// one strobe bit per byte of the access
	assign size_mask = (STRB_W'(1) << op_size(op)) - STRB_W'(1);

	// 16 byte lanes, lanes 8..15 belong to the second beat
	assign data_image = {{(2*BEAT_W-XLEN){1'b0}}, store_data} << {offset, 3'b000};
	assign strb_image = {{STRB_W{1'b0}}, size_mask} << offset;

	assign beat0_wdata = data_image[BEAT_W-1:0];
	assign beat1_wdata = data_image[2*BEAT_W-1:BEAT_W];
	assign beat0_strb = strb_image[STRB_W-1:0];
	assign beat1_strb = strb_image[2*STRB_W-1:STRB_W];

endmodule

/* verilog/write_channel.sv */
`timescale 1ns/1ps

module write_channel (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             wr_start,
	input  logic                             two_beats,
	input  logic [lsu_pkg::XLEN-1:0]         beat_addr,
	input  logic [mem_bus_pkg::BEAT_W-1:0]   beat0_wdata,
	input  logic [mem_bus_pkg::BEAT_W-1:0]   beat1_wdata,
	input  logic [mem_bus_pkg::STRB_W-1:0]   beat0_strb,
	input  logic [mem_bus_pkg::STRB_W-1:0]   beat1_strb,
	input  logic                             awready,
	input  logic                             wready,
	input  logic                             bvalid,
	output logic                             awvalid,
	output logic [lsu_pkg::XLEN-1:0]         awaddr,
	output logic                             wvalid,
	output logic [mem_bus_pkg::BEAT_W-1:0]   wdata,
	output logic [mem_bus_pkg::STRB_W-1:0]   wstrb,
	output logic                             bready,
	output logic                             wr_done
);
	import lsu_pkg::*;
	import mem_bus_pkg::*;

	wr_state_e state;
	wr_state_e state_next;
	logic      second_beat;

	always_ff @(posedge clock) begin
		if (reset)
			state <= WR_IDLE0;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			WR_IDLE0: if (wr_start) state_next = WR_ADDR0;
			WR_ADDR0: if (awready) state_next = WR_DATA0;
			WR_DATA0: if (wready) state_next = WR_RESP0;
			WR_RESP0: if (bvalid) state_next = two_beats ? WR_IDLE1 : WR_IDLE0;
			// gap cycle before the upper beat
			WR_IDLE1: state_next = WR_ADDR1;
			WR_ADDR1: if (awready) state_next = WR_DATA1;
			WR_DATA1: if (wready) state_next = WR_RESP1;
			WR_RESP1: if (bvalid) state_next = WR_IDLE0;
			default: state_next = WR_IDLE0;
		endcase
	end

	// done one cycle after the last response handshake
	always_ff @(posedge clock) begin
		if (reset)
			wr_done <= 1'b0;
		else
			wr_done <= bvalid && ((state == WR_RESP0 && !two_beats) || state == WR_RESP1);
	end

	assign second_beat = state inside {WR_IDLE1, WR_ADDR1, WR_DATA1, WR_RESP1};

	assign awvalid = (state == WR_ADDR0) || (state == WR_ADDR1);
	assign wvalid = (state == WR_DATA0) || (state == WR_DATA1);
	assign bready = (state == WR_RESP0) || (state == WR_RESP1);
	assign awaddr = second_beat ? beat_addr + XLEN'(BEAT_BYTES) : beat_addr;
	assign wdata = second_beat ? beat1_wdata : beat0_wdata;
	assign wstrb = second_beat ? beat1_strb : beat0_strb;

	assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr));
	assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata));

endmodule

/* verilog/read_channel.sv */
`timescale 1ns/1ps

module read_channel (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             rd_start,
	input  logic                             two_beats,
	input  logic [lsu_pkg::XLEN-1:0]         beat_addr,
	input  logic                             arready,
	input  logic                             rvalid,
	input  logic [mem_bus_pkg::BEAT_W-1:0]   rdata,
	output logic                             arvalid,
	output logic [lsu_pkg::XLEN-1:0]         araddr,
	output logic                             rready,
	output logic [mem_bus_pkg::BEAT_W-1:0]   beat0_data,
	output logic [mem_bus_pkg::BEAT_W-1:0]   beat1_data,
	output logic                             rd_done
);
	import lsu_pkg::*;
	import mem_bus_pkg::*;

	rd_state_e state;
	rd_state_e state_next;
	logic      second_beat;

	always_ff @(posedge clock) begin
		if (reset)
			state <= RD_IDLE0;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			RD_IDLE0: if (rd_start) state_next = RD_ADDR0;
			RD_ADDR0: if (arready) state_next = RD_DATA0;
			RD_DATA0: if (rvalid) state_next = two_beats ? RD_IDLE1 : RD_IDLE0;
			RD_IDLE1: state_next = RD_ADDR1;
			RD_ADDR1: if (arready) state_next = RD_DATA1;
			RD_DATA1: if (rvalid) state_next = RD_IDLE0;
			default: state_next = RD_IDLE0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			rd_done <= 1'b0;
		else
			rd_done <= rvalid && ((state == RD_DATA0 && !two_beats) || state == RD_DATA1);
	end

	// each beat lands in its own register on the data handshake
	always_ff @(posedge clock) begin
		if (rvalid && rready && state == RD_DATA0)
			beat0_data <= rdata;
		if (rvalid && rready && state == RD_DATA1)
			beat1_data <= rdata;
	end

	assign second_beat = state inside {RD_IDLE1, RD_ADDR1, RD_DATA1};

	assign arvalid = (state == RD_ADDR0) || (state == RD_ADDR1);
	assign rready = (state == RD_DATA0) || (state == RD_DATA1);
	assign araddr = second_beat ? beat_addr + XLEN'(BEAT_BYTES) : beat_addr;

	assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

/* verilog/load_extract.sv */
`timescale 1ns/1ps

module load_extract (
	input  lsu_pkg::mem_op_e                   op,
	input  logic [mem_bus_pkg::OFFSET_W-1:0]   offset,
	input  logic [mem_bus_pkg::BEAT_W-1:0]     beat0_data,
	input  logic [mem_bus_pkg::BEAT_W-1:0]     beat1_data,
	output logic [lsu_pkg::XLEN-1:0]           load_data
);
	import lsu_pkg::*;
	import mem_bus_pkg::*;

	logic [2*BEAT_W-1:0] lanes;
	logic [XLEN-1:0]     raw;

	// bytes from the offset onward, beat 1 supplies lanes 8..15
	assign lanes = {beat1_data, beat0_data} >> {offset, 3'b000};
	assign raw = lanes[XLEN-1:0];

	always_comb begin
		case (op)
			OP_LB: load_data = {{(XLEN-8){raw[7]}}, raw[7:0]};
			OP_LBU: load_data = {{(XLEN-8){1'b0}}, raw[7:0]};
			OP_LH: load_data = {{(XLEN-16){raw[15]}}, raw[15:0]};
			OP_LHU: load_data = {{(XLEN-16){1'b0}}, raw[15:0]};
			// full word, also what stores see
			default: load_data = raw;
		endcase
	end

endmodule

/* verilog/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             req_valid,
	input  lsu_pkg::mem_op_e                 req_op,
	input  logic [lsu_pkg::XLEN-1:0]         req_addr,
	input  logic [lsu_pkg::XLEN-1:0]         req_wdata,
	input  lsu_pkg::reg_addr_t               req_rd,
	input  logic                             awready,
	input  logic                             wready,
	input  logic                             bvalid,
	input  logic                             arready,
	input  logic                             rvalid,
	input  logic [mem_bus_pkg::BEAT_W-1:0]   rdata,
	output logic                             req_ready,
	output logic                             mem_done,
	output logic                             rf_wen,
	output lsu_pkg::reg_addr_t               rf_waddr,
	output logic [lsu_pkg::XLEN-1:0]         rf_wdata,
	output logic                             awvalid,
	output logic [lsu_pkg::XLEN-1:0]         awaddr,
	output logic                             wvalid,
	output logic [mem_bus_pkg::BEAT_W-1:0]   wdata,
	output logic [mem_bus_pkg::STRB_W-1:0]   wstrb,
	output logic                             bready,
	output logic                             arvalid,
	output logic [lsu_pkg::XLEN-1:0]         araddr,
	output logic                             rready
);
	import lsu_pkg::*;
	import mem_bus_pkg::*;

	mem_op_e               op;
	logic [OFFSET_W-1:0]   offset;
	logic [XLEN-1:0]       store_data;
	logic [XLEN-1:0]       beat_addr;
	logic                  two_beats;
	logic                  wr_start;
	logic                  rd_start;
	logic                  wr_done;
	logic                  rd_done;
	logic [BEAT_W-1:0]     beat0_wdata;
	logic [BEAT_W-1:0]     beat1_wdata;
	logic [STRB_W-1:0]     beat0_strb;
	logic [STRB_W-1:0]     beat1_strb;
	logic [BEAT_W-1:0]     beat0_data;
	logic [BEAT_W-1:0]     beat1_data;

	lsu_issue u_lsu_issue (
		.clock(clock), .reset(reset),
		.req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
		.req_wdata(req_wdata), .req_rd(req_rd),
		.wr_done(wr_done), .rd_done(rd_done), .req_ready(req_ready),
		.op(op), .offset(offset), .store_data(store_data), .beat_addr(beat_addr),
		.two_beats(two_beats), .wr_start(wr_start), .rd_start(rd_start),
		.mem_done(mem_done), .rf_wen(rf_wen), .rf_waddr(rf_waddr)
	);

	store_align u_store_align (
		.op(op), .offset(offset), .store_data(store_data),
		.beat0_wdata(beat0_wdata), .beat1_wdata(beat1_wdata),
		.beat0_strb(beat0_strb), .beat1_strb(beat1_strb)
	);

	write_channel u_write_channel (
		.clock(clock), .reset(reset), .wr_start(wr_start), .two_beats(two_beats),
		.beat_addr(beat_addr), .beat0_wdata(beat0_wdata), .beat1_wdata(beat1_wdata),
		.beat0_strb(beat0_strb), .beat1_strb(beat1_strb),
		.awready(awready), .wready(wready), .bvalid(bvalid),
		.awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
		.wstrb(wstrb), .bready(bready), .wr_done(wr_done)
	);

	read_channel u_read_channel (
		.clock(clock), .reset(reset), .rd_start(rd_start), .two_beats(two_beats),
		.beat_addr(beat_addr), .arready(arready), .rvalid(rvalid), .rdata(rdata),
		.arvalid(arvalid), .araddr(araddr), .rready(rready),
		.beat0_data(beat0_data), .beat1_data(beat1_data), .rd_done(rd_done)
	);

	load_extract u_load_extract (
		.op(op), .offset(offset), .beat0_data(beat0_data), .beat1_data(beat1_data),
		.load_data(rf_wdata)
	);

endmodule

/* verif/lsu_top_tb.sv */
`timescale 1ns/1ps

module lsu_top_tb;
	import lsu_pkg::*;
	import mem_bus_pkg::*;

	localparam int NUM_TESTS = 33;
	localparam int CYCLE_LIMIT = NUM_TESTS * 40;

	typedef struct {
		mem_op_e         op;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
		reg_addr_t       rd;
		logic [XLEN-1:0] load_value;
	} entry_t;

	logic clock;
	logic reset;
	logic req_valid;
	mem_op_e req_op;
	logic [XLEN-1:0] req_addr;
	logic [XLEN-1:0] req_wdata;
	reg_addr_t req_rd;
	logic awready = 1'b0;
	logic wready = 1'b0;
	logic bvalid = 1'b0;
	logic arready = 1'b0;
	logic rvalid = 1'b0;
	logic [BEAT_W-1:0] rdata = '0;
	logic req_ready, mem_done, rf_wen, awvalid, wvalid, bready, arvalid, rready;
	reg_addr_t rf_waddr;
	logic [XLEN-1:0] rf_wdata, awaddr, araddr;
	logic [BEAT_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;

	// memory model state
	logic [7:0] mem [0:255];
	logic [XLEN-1:0] aw_addr_q;
	logic b_pend = 1'b0;
	logic r_pend = 1'b0;
	logic [1:0] delay = 2'd0;
	logic [31:0] lfsr = 32'h2d79;
	mem_op_e cur_op;
	logic [XLEN-1:0] cur_addr;
	int beats = 0;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	entry_t tests [NUM_TESTS];

	lsu_top u_lsu_top (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] galois_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic take_bit();
		lfsr = galois_step(lfsr);
		return lfsr[0];
	endfunction

	function automatic int access_bytes(mem_op_e op);
		case (op)
			OP_LB, OP_LBU, OP_SB: return 1;
			OP_LH, OP_LHU, OP_SH: return 2;
			default: return 4;
		endcase
	endfunction

	// byte lanes 0..15 touched by the access, upper byte is beat 1
	function automatic logic [15:0] lane_mask(mem_op_e op, logic [XLEN-1:0] addr);
		return ((16'd1 << access_bytes(op)) - 16'd1) << addr[2:0];
	endfunction

	task automatic check_word(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_reg(string name, reg_addr_t got, reg_addr_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_strb(string name, logic [STRB_W-1:0] got, logic [STRB_W-1:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_flag(string name, logic got, logic want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, want);
		end
	endtask

	// bus responder, one channel stage at a time with a random wait before each ready
	always @(posedge clock) begin
		if (reset) begin
			{awready, wready, bvalid, arready, rvalid} <= '0;
			b_pend <= 1'b0;
			r_pend <= 1'b0;
			delay <= 2'd0;
		end else if ((awvalid && awready) || (wvalid && wready) || (bvalid && bready)
				|| (arvalid && arready) || (rvalid && rready)) begin
			if (awvalid && awready) begin
				beats = beats + 1;
				check_word("awaddr", awaddr,
					{cur_addr[XLEN-1:3], 3'b000} + XLEN'(8 * (beats - 1)));
				aw_addr_q <= awaddr;
			end
			if (wvalid && wready) begin
				check_strb("wstrb", wstrb,
					STRB_W'(lane_mask(cur_op, cur_addr) >> (8 * (beats - 1))));
				for (int i = 0; i < BEAT_BYTES; i++)
					if (wstrb[i])
						mem[aw_addr_q[7:0] + 8'(i)] = wdata[8*i +: 8];
				b_pend <= 1'b1;
			end
			if (arvalid && arready) begin
				beats = beats + 1;
				check_word("araddr", araddr,
					{cur_addr[XLEN-1:3], 3'b000} + XLEN'(8 * (beats - 1)));
				for (int i = 0; i < BEAT_BYTES; i++)
					rdata[8*i +: 8] <= mem[araddr[7:0] + 8'(i)];
				r_pend <= 1'b1;
			end
			if (bvalid && bready)
				b_pend <= 1'b0;
			if (rvalid && rready)
				r_pend <= 1'b0;
			{awready, wready, bvalid, arready, rvalid} <= '0;
			delay <= {take_bit(), take_bit()};
		end else if (delay != 2'd0) begin
			delay <= delay - 2'd1;
		end else begin
			awready <= awvalid;
			wready <= wvalid;
			arready <= arvalid;
			bvalid <= b_pend;
			rvalid <= r_pend;
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// memory starts out holding its own address in every byte
	task automatic fill_table();
		tests[0] = '{OP_LW, 32'h10, 32'h0, 5'd1, 32'h13121110};
		tests[1] = '{OP_LW, 32'h94, 32'h0, 5'd2, 32'h97969594};
		tests[2] = '{OP_LH, 32'h84, 32'h0, 5'd3, 32'hffff8584};
		tests[3] = '{OP_LHU, 32'h80, 32'h0, 5'd4, 32'h00008180};
		tests[4] = '{OP_LB, 32'h84, 32'h0, 5'd5, 32'hffffff84};
		tests[5] = '{OP_LBU, 32'h80, 32'h0, 5'd6, 32'h00000080};
		tests[6] = '{OP_LB, 32'h14, 32'h0, 5'd7, 32'h00000014};
		tests[7] = '{OP_LW, 32'h25, 32'h0, 5'd8, 32'h28272625};
		tests[8] = '{OP_LW, 32'h37, 32'h0, 5'd9, 32'h3a393837};
		tests[9] = '{OP_LH, 32'h8f, 32'h0, 5'd10, 32'hffff908f};
		tests[10] = '{OP_LHU, 32'h8f, 32'h0, 5'd11, 32'h0000908f};
		tests[11] = '{OP_SB, 32'h41, 32'h000000c3, 5'd12, 32'h0};
		tests[12] = '{OP_SH, 32'h46, 32'h0000b2a1, 5'd13, 32'h0};
		tests[13] = '{OP_SW, 32'h4b, 32'h44332211, 5'd14, 32'h0};
		tests[14] = '{OP_LW, 32'h40, 32'h0, 5'd15, 32'h4342c340};
		tests[15] = '{OP_LW, 32'h44, 32'h0, 5'd16, 32'hb2a14544};
		tests[16] = '{OP_LW, 32'h4c, 32'h0, 5'd17, 32'h4f443322};
		tests[17] = '{OP_LBU, 32'h4b, 32'h0, 5'd18, 32'h00000011};
		tests[18] = '{OP_SH, 32'h57, 32'h0000e5d4, 5'd19, 32'h0};
		tests[19] = '{OP_SW, 32'h6e, 32'h88776655, 5'd20, 32'h0};
		tests[20] = '{OP_LW, 32'h55, 32'h0, 5'd21, 32'he5d45655};
		tests[21] = '{OP_LW, 32'h6c, 32'h0, 5'd22, 32'h66556d6c};
		tests[22] = '{OP_LW, 32'h70, 32'h0, 5'd23, 32'h73728877};
		tests[23] = '{OP_SB, 32'h7f, 32'h0000005a, 5'd24, 32'h0};
		tests[24] = '{OP_LH, 32'h7f, 32'h0, 5'd25, 32'hffff805a};
		tests[25] = '{OP_LBU, 32'h59, 32'h0, 5'd26, 32'h00000059};
		// stores at the remaining offsets 0, 2, 4 and 5
		tests[26] = '{OP_SB, 32'h60, 32'h000000a5, 5'd27, 32'h0};
		tests[27] = '{OP_SH, 32'h62, 32'h0000c7b6, 5'd28, 32'h0};
		tests[28] = '{OP_SW, 32'h9c, 32'hddccbbaa, 5'd29, 32'h0};
		tests[29] = '{OP_SB, 32'h65, 32'h0000003c, 5'd30, 32'h0};
		tests[30] = '{OP_LW, 32'h60, 32'h0, 5'd31, 32'hc7b661a5};
		tests[31] = '{OP_LW, 32'h9c, 32'h0, 5'd1, 32'hddccbbaa};
		tests[32] = '{OP_LBU, 32'h65, 32'h0, 5'd2, 32'h0000003c};
	endtask

	task automatic run_entry(entry_t e);
		logic load;
		int want_beats;
		load = !(e.op inside {OP_SB, OP_SH, OP_SW});
		want_beats = (e.addr[2:0] + access_bytes(e.op) > 8) ? 2 : 1;
		@(posedge clock);
		cur_op = e.op;
		cur_addr = e.addr;
		beats = 0;
		req_valid <= 1'b1;
		req_op <= e.op;
		req_addr <= e.addr;
		req_wdata <= e.wdata;
		req_rd <= e.rd;
		@(negedge clock);
		check_flag("req_ready", req_ready, 1'b1);
		@(posedge clock);
		req_valid <= 1'b0;
		@(negedge clock);
		// busy until the done pulse
		while (mem_done !== 1'b1) begin
			check_flag("req_ready", req_ready, 1'b0);
			@(negedge clock);
		end
		check_flag("req_ready", req_ready, 1'b0);
		check_flag("rf_wen", rf_wen, load);
		if (load) begin
			check_reg("rf_waddr", rf_waddr, e.rd);
			check_word("rf_wdata", rf_wdata, e.load_value);
		end
		check_word("bus beats", XLEN'(beats), XLEN'(want_beats));
		@(negedge clock);
		check_flag("mem_done", mem_done, 1'b0);
		check_flag("req_ready", req_ready, 1'b1);
	endtask

	initial begin
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = OP_LB;
		req_addr = '0;
		req_wdata = '0;
		req_rd = '0;
		for (int a = 0; a < 256; a++)
			mem[a] = 8'(a);
		fill_table();
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_flag("awvalid", awvalid, 1'b0);
		check_flag("wvalid", wvalid, 1'b0);
		check_flag("bready", bready, 1'b0);
		check_flag("arvalid", arvalid, 1'b0);
		check_flag("rready", rready, 1'b0);
		check_flag("mem_done", mem_done, 1'b0);
		check_flag("rf_wen", rf_wen, 1'b0);
		check_flag("req_ready", req_ready, 1'b1);
		for (int t = 0; t < NUM_TESTS; t++)
			run_entry(tests[t]);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* lsu_top.f */
verilog/lsu_pkg.sv
verilog/mem_bus_pkg.sv
verilog/lsu_issue.sv
verilog/store_align.sv
verilog/write_channel.sv
verilog/read_channel.sv
verilog/load_extract.sv
verilog/lsu_top.sv
verif/lsu_top_tb.sv
